//--- src/fm_regs_pkg.sv
/*
 * register map of the sound chip
 * decoded register addresses as an enum, timer control bit positions,
 * pin and pan bit positions, level shift width
 */

package fm_regs_pkg;

    // registers the decoder acts on, anything else is dropped
    typedef enum logic [7:0] {
        ADDR_CLKA_HI    = 8'h10,    // timer A value 9..2
        ADDR_CLKA_LO    = 8'h11,    // timer A value 1..0
        ADDR_CLKB       = 8'h12,
        ADDR_TIMER_CTRL = 8'h14,
        ADDR_CT         = 8'h1B,
        ADDR_PAN        = 8'h20,
        ADDR_INC_HI     = 8'h28,
        ADDR_INC_LO     = 8'h30,
        ADDR_ATTEN      = 8'h60
    } reg_addr_e;

    // timer control register
    localparam int CTRL_RUN_A    = 0;
    localparam int CTRL_RUN_B    = 1;
    localparam int CTRL_IRQ_EN_A = 2;
    localparam int CTRL_IRQ_EN_B = 3;
    localparam int CTRL_CLR_A    = 4;   // write 1 to clear flag A
    localparam int CTRL_CLR_B    = 5;

    // CT register, output pins
    localparam int CT1_BIT = 6;
    localparam int CT2_BIT = 7;

    // pan register
    localparam int PAN_LEFT_BIT  = 6;
    localparam int PAN_RIGHT_BIT = 7;

    localparam int ATTEN_W = 3;     // level shift field, bits 2..0

endpackage

//--- src/fm_timing_pkg.sv
/*
 * timing constants and widths
 * busy hold-off, sample divider, timer widths and prescaler, voice widths
 */

package fm_timing_pkg;

    localparam int BUSY_CEN = 16;           // cen ticks of busy after a data write
    localparam int BUSY_W   = $clog2(BUSY_CEN + 1);
    localparam logic [BUSY_W-1:0] BUSY_LOAD = BUSY_W'(BUSY_CEN);

    localparam int SAMPLE_DIV = 32;         // cen ticks per output sample
    localparam int SAMPLE_W   = $clog2(SAMPLE_DIV);
    localparam logic [SAMPLE_W-1:0] SAMPLE_LAST = SAMPLE_W'(SAMPLE_DIV - 1);

    localparam int TIMER_A_W = 10;
    localparam int TIMER_B_W = 8;

    localparam int TIMER_B_PRESCALE = 16;   // cen ticks per timer B count
    localparam int PRESCALE_W       = $clog2(TIMER_B_PRESCALE);
    localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(TIMER_B_PRESCALE - 1);

    localparam int PHASE_W = 16;
    localparam logic signed [15:0] AMP_FULL = 16'sh4000;   // square level before shift

endpackage

//--- src/fm_mmr.sv
/*
 * host bus decoder and register file
 * address latch, data write decode, timer/voice/pin registers,
 * one-cycle flag clear pulses and the busy hold-off counter
 */

module fm_mmr (
    input  logic                                clk,
    input  logic                                cen,
    input  logic                                rst_n,
    input  logic                                a0,
    input  logic                                write,
    input  logic [7:0]                          din,
    output logic                                busy,
    output logic                                ct1,
    output logic                                ct2,
    output logic [fm_timing_pkg::TIMER_A_W-1:0] value_a,
    output logic [fm_timing_pkg::TIMER_B_W-1:0] value_b,
    output logic                                run_a,
    output logic                                run_b,
    output logic                                irq_en_a,
    output logic                                irq_en_b,
    output logic                                clr_flag_a,
    output logic                                clr_flag_b,
    output logic [fm_timing_pkg::PHASE_W-1:0]   phase_inc,
    output logic                                pan_left,
    output logic                                pan_right,
    output logic [fm_regs_pkg::ATTEN_W-1:0]     atten
);

    logic [7:0]                       sel_addr;   // last address byte from the host
    logic [fm_timing_pkg::BUSY_W-1:0] busy_cnt;
    logic                             data_wr;

    // data writes while busy are lost, the host has to poll status
    assign data_wr = write && a0 && !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_addr <= '0;
        end else if (write && !a0) begin
            sel_addr <= din;
        end
    end

    // busy hold-off, counts cen-high cycles only
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= fm_timing_pkg::BUSY_LOAD;
        end else if (cen && busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
            if (busy_cnt == 1) begin
                busy <= 1'b0;   // last tick of the hold-off
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ct1        <= 1'b0;
            ct2        <= 1'b0;
            value_a    <= '0;
            value_b    <= '0;
            run_a      <= 1'b0;
            run_b      <= 1'b0;
            irq_en_a   <= 1'b0;
            irq_en_b   <= 1'b0;
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
            phase_inc  <= '0;
            pan_left   <= 1'b0;
            pan_right  <= 1'b0;
            atten      <= '0;
        end else begin
            clr_flag_a <= 1'b0; // pulses last one cycle
            clr_flag_b <= 1'b0;
            if (data_wr) begin
                case (sel_addr)
                    fm_regs_pkg::ADDR_CT: begin
                        ct1 <= din[fm_regs_pkg::CT1_BIT];
                        ct2 <= din[fm_regs_pkg::CT2_BIT];
                    end
                    fm_regs_pkg::ADDR_CLKA_HI: value_a[fm_timing_pkg::TIMER_A_W-1:2] <= din;
                    fm_regs_pkg::ADDR_CLKA_LO: value_a[1:0] <= din[1:0];
                    fm_regs_pkg::ADDR_CLKB:    value_b <= din;
                    fm_regs_pkg::ADDR_TIMER_CTRL: begin
                        run_a      <= din[fm_regs_pkg::CTRL_RUN_A];
                        run_b      <= din[fm_regs_pkg::CTRL_RUN_B];
                        irq_en_a   <= din[fm_regs_pkg::CTRL_IRQ_EN_A];
                        irq_en_b   <= din[fm_regs_pkg::CTRL_IRQ_EN_B];
                        clr_flag_a <= din[fm_regs_pkg::CTRL_CLR_A];
                        clr_flag_b <= din[fm_regs_pkg::CTRL_CLR_B];
                    end
                    fm_regs_pkg::ADDR_PAN: begin
                        pan_left  <= din[fm_regs_pkg::PAN_LEFT_BIT];
                        pan_right <= din[fm_regs_pkg::PAN_RIGHT_BIT];
                    end
                    fm_regs_pkg::ADDR_INC_HI: phase_inc[fm_timing_pkg::PHASE_W-1:8] <= din;
                    fm_regs_pkg::ADDR_INC_LO: phase_inc[7:0] <= din;
                    fm_regs_pkg::ADDR_ATTEN:  atten <= din[fm_regs_pkg::ATTEN_W-1:0];
                    default: ;  // unmapped address, write dropped
                endcase
            end
        end
    end

    // busy and its counter have to stay in step
    busy_cnt_consistent: assert property (
        @(posedge clk) disable iff (!rst_n) busy |-> (busy_cnt != '0)
    );

endmodule

//--- src/fm_timers.sv
/*
 * interval timers A and B
 * reloading up-counters, timer B prescaler, sticky overflow flags, irq_n
 */

module fm_timers (
    input  logic                                clk,
    input  logic                                cen,
    input  logic                                rst_n,
    input  logic [fm_timing_pkg::TIMER_A_W-1:0] value_a,
    input  logic [fm_timing_pkg::TIMER_B_W-1:0] value_b,
    input  logic                                run_a,
    input  logic                                run_b,
    input  logic                                irq_en_a,
    input  logic                                irq_en_b,
    input  logic                                clr_flag_a,
    input  logic                                clr_flag_b,
    output logic                                flag_a,
    output logic                                flag_b,
    output logic                                irq_n
);

    logic [fm_timing_pkg::TIMER_A_W-1:0]  cnt_a;
    logic [fm_timing_pkg::TIMER_B_W-1:0]  cnt_b;
    logic [fm_timing_pkg::PRESCALE_W-1:0] pre_cnt;
    logic                                 run_a_d;
    logic                                 run_b_d;
    logic                                 load_a;
    logic                                 load_b;
    logic                                 tick_b;
    logic                                 ovf_a;
    logic                                 ovf_b;

    assign load_a = run_a && !run_a_d;     // run rising edge
    assign load_b = run_b && !run_b_d;
    assign tick_b = cen && (pre_cnt == fm_timing_pkg::PRESCALE_LAST);

    // overflow is the count after all ones
    assign ovf_a = run_a && !load_a && cen && (cnt_a == '1);
    assign ovf_b = run_b && !load_b && tick_b && (cnt_b == '1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_a_d <= 1'b0;
            run_b_d <= 1'b0;
            pre_cnt <= '0;
            cnt_a   <= '0;
            cnt_b   <= '0;
        end else begin
            run_a_d <= run_a;
            run_b_d <= run_b;
            if (cen) pre_cnt <= pre_cnt + 1'b1;   // free running

            if (load_a || ovf_a)        cnt_a <= value_a;
            else if (run_a && cen)      cnt_a <= cnt_a + 1'b1;

            if (load_b || ovf_b)        cnt_b <= value_b;
            else if (run_b && tick_b)   cnt_b <= cnt_b + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
            irq_n  <= 1'b1;
        end else begin
            if (clr_flag_a)               flag_a <= 1'b0;
            else if (ovf_a && irq_en_a)   flag_a <= 1'b1;
            if (clr_flag_b)               flag_b <= 1'b0;
            else if (ovf_b && irq_en_b)   flag_b <= 1'b1;
            irq_n <= !(flag_a || flag_b);
        end
    end

    // a disabled timer never raises its flag
    flag_a_needs_en: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(flag_a) |-> $past(irq_en_a)
    );
    flag_b_needs_en: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(flag_b) |-> $past(irq_en_b)
    );

endmodule

//--- src/fm_voice.sv
/*
 * single tone voice
 * sample strobe divider, phase accumulator, square level with shift and pan,
 * offset-binary DAC outputs
 */

module fm_voice (
    input  logic                              clk,
    input  logic                              cen,
    input  logic                              rst_n,
    input  logic [fm_timing_pkg::PHASE_W-1:0] phase_inc,
    input  logic                              pan_left,
    input  logic                              pan_right,
    input  logic [fm_regs_pkg::ATTEN_W-1:0]   atten,
    output logic                              sample,
    output logic signed [15:0]                left,
    output logic signed [15:0]                right,
    output logic [15:0]                       dac_left,
    output logic [15:0]                       dac_right
);

    logic [fm_timing_pkg::SAMPLE_W-1:0] div_cnt;
    logic [fm_timing_pkg::PHASE_W-1:0]  phase;
    logic [fm_timing_pkg::PHASE_W-1:0]  phase_next;
    logic                               tick;
    logic signed [15:0]                 level;
    logic signed [15:0]                 level_sh;

    assign tick       = cen && (div_cnt == fm_timing_pkg::SAMPLE_LAST);
    assign phase_next = phase + phase_inc;

    // first half of the cycle is positive
    assign level    = phase_next[fm_timing_pkg::PHASE_W-1] ? -fm_timing_pkg::AMP_FULL
                                                            : fm_timing_pkg::AMP_FULL;
    assign level_sh = level >>> atten;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
            sample  <= 1'b0;
            phase   <= '0;
            left    <= '0;
            right   <= '0;
        end else begin
            if (cen) div_cnt <= div_cnt + 1'b1;   // wraps at SAMPLE_DIV
            sample <= tick;
            if (tick) begin
                phase <= phase_next;
                left  <= pan_left  ? level_sh : 16'sd0;
                right <= pan_right ? level_sh : 16'sd0;
            end
        end
    end

    // flip the sign bit for an unsigned converter
    assign dac_left  = {~left[15],  left[14:0]};
    assign dac_right = {~right[15], right[14:0]};

    sample_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) sample |=> !sample
    );

endmodule

//--- src/fm_chip.sv
/*
 * sound chip top level
 * register file, timers and voice, host write strobe and status byte
 */

module fm_chip (
    input  logic               clk,
    input  logic               cen,
    input  logic               rst_n,
    input  logic               cs_n,
    input  logic               wr_n,
    input  logic               a0,
    input  logic [7:0]         din,
    output logic [7:0]         dout,
    output logic               ct1,
    output logic               ct2,
    output logic               irq_n,
    output logic               sample,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic [15:0]        dac_left,
    output logic [15:0]        dac_right
);

    logic                                write;
    logic                                busy;
    logic [fm_timing_pkg::TIMER_A_W-1:0] value_a;
    logic [fm_timing_pkg::TIMER_B_W-1:0] value_b;
    logic                                run_a, run_b;
    logic                                irq_en_a, irq_en_b;
    logic                                clr_flag_a, clr_flag_b;
    logic                                flag_a, flag_b;
    logic [fm_timing_pkg::PHASE_W-1:0]   phase_inc;
    logic                                pan_left, pan_right;
    logic [fm_regs_pkg::ATTEN_W-1:0]     atten;

    assign write = !cs_n && !wr_n;
    assign dout  = {busy, 5'h0, flag_b, flag_a};   // status byte, always readable

    fm_mmr u_mmr (
        .clk(clk), .cen(cen), .rst_n(rst_n),
        .a0(a0), .write(write), .din(din),
        .busy(busy), .ct1(ct1), .ct2(ct2),
        .value_a(value_a), .value_b(value_b),
        .run_a(run_a), .run_b(run_b),
        .irq_en_a(irq_en_a), .irq_en_b(irq_en_b),
        .clr_flag_a(clr_flag_a), .clr_flag_b(clr_flag_b),
        .phase_inc(phase_inc), .pan_left(pan_left), .pan_right(pan_right),
        .atten(atten)
    );

    fm_timers u_timers (
        .clk(clk), .cen(cen), .rst_n(rst_n),
        .value_a(value_a), .value_b(value_b),
        .run_a(run_a), .run_b(run_b),
        .irq_en_a(irq_en_a), .irq_en_b(irq_en_b),
        .clr_flag_a(clr_flag_a), .clr_flag_b(clr_flag_b),
        .flag_a(flag_a), .flag_b(flag_b), .irq_n(irq_n)
    );

    fm_voice u_voice (
        .clk(clk), .cen(cen), .rst_n(rst_n),
        .phase_inc(phase_inc), .pan_left(pan_left), .pan_right(pan_right),
        .atten(atten),
        .sample(sample), .left(left), .right(right),
        .dac_left(dac_left), .dac_right(dac_right)
    );

endmodule

//--- verification/fm_chip_tb.sv
/*
 * testbench for the sound chip top level
 * clock, cen pattern, reset, host bus write tasks, directed tests,
 * voice phase model and cycle limit
 */

module fm_chip_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 20000;  // worst test lengths summed, with margin

    logic               clk;
    logic               cen;
    logic               rst_n;
    logic               cs_n;
    logic               wr_n;
    logic               a0;
    logic [7:0]         din;
    logic [7:0]         dout;
    logic               ct1;
    logic               ct2;
    logic               irq_n;
    logic               sample;
    logic signed [15:0] left;
    logic signed [15:0] right;
    logic [15:0]        dac_left;
    logic [15:0]        dac_right;

    int          errors      = 0;
    int          cyc         = 0;
    logic        half_cen    = 1'b0;    // cen high every other cycle
    logic [15:0] inc_old     = '0;
    logic [15:0] inc_new     = '0;
    int          inc_at      = 0;       // cycle of the last increment write
    logic [15:0] model_phase = '0;

    fm_chip i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = !clk;
    end

    initial begin
        cen = 1'b1;
        forever begin
            @(posedge clk);
            #1 cen = half_cen ? !cen : 1'b1;
        end
    end

    initial begin
        while (cyc < MAX_CYCLES) begin
            @(posedge clk);
            cyc++;
        end
        $display("run stopped at the cycle limit of %0d", MAX_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // a tick on the write edge still sees the old increment
    initial begin
        forever begin
            @(negedge clk);
            if (sample) model_phase = model_phase + ((cyc > inc_at) ? inc_new : inc_old);
        end
    end

    task automatic check_eq(string name, logic [15:0] exp, logic [15:0] act);
        assert (act == exp) else begin
            errors++;
            $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic bus_cycle(logic sel, logic [7:0] val);
        a0   = sel;
        din  = val;
        cs_n = 1'b0;
        wr_n = 1'b0;
        next_cycle();
        cs_n = 1'b1;
        wr_n = 1'b1;
    endtask

    task automatic bus_addr(logic [7:0] addr);
        bus_cycle(1'b0, addr);
    endtask

    task automatic bus_data(logic [7:0] val);
        bus_cycle(1'b1, val);
    endtask

    task automatic reg_write(fm_regs_pkg::reg_addr_e addr, logic [7:0] val);
        while (dout[7]) next_cycle();   // poll busy
        bus_addr(addr);
        bus_data(val);
        if (addr == fm_regs_pkg::ADDR_INC_HI || addr == fm_regs_pkg::ADDR_INC_LO) begin
            inc_old = inc_new;
            inc_new = (addr == fm_regs_pkg::ADDR_INC_HI) ? {val, inc_new[7:0]}
                                                          : {inc_new[15:8], val};
            inc_at  = cyc;
        end
    endtask

    // wait for a status bit and check the cycle count against the window
    task automatic time_flag(string name, logic [2:0] bit_idx, int lo, int hi);
        int cycles;
        cycles = 0;
        while (!dout[bit_idx] && cycles <= hi) begin
            next_cycle();
            cycles++;
        end
        assert (cycles >= lo && cycles <= hi) else begin
            errors++;
            $display("%s: flag after %0d cycles, expected %0d to %0d", name, cycles, lo, hi);
        end
    endtask

    // square wave from the phase msb, level shift and pan gate
    function automatic logic [15:0] square_level(logic [15:0] ph, logic [2:0] sh, logic en);
        logic [15:0] mag;
        mag = fm_timing_pkg::AMP_FULL >> sh;
        if (!en) return 16'h0;
        return ph[15] ? -mag : mag;
    endfunction

    task automatic timer_a_flag(string name, int scale, output int period);
        logic [9:0] val;
        val    = 10'd512 + 10'($urandom_range(479));
        period = 1024 - int'(val);
        reg_write(fm_regs_pkg::ADDR_CLKA_HI, val[9:2]);
        reg_write(fm_regs_pkg::ADDR_CLKA_LO, {6'h0, val[1:0]});
        reg_write(fm_regs_pkg::ADDR_TIMER_CTRL, 8'h05);   // run A, irq enable A
        time_flag(name, 0, scale * period - 1, scale * period + 2);
    endtask

    task automatic test_reset();
        check_eq("reset dout", 16'h00, 16'(dout));
        check_eq("reset irq_n", 16'h1, 16'(irq_n));
        check_eq("reset ct pins", 16'h0, 16'({ct2, ct1}));
        check_eq("reset sample", 16'h0, 16'(sample));
        check_eq("reset dac_left", 16'h8000, dac_left);
        check_eq("reset dac_right", 16'h8000, dac_right);
    endtask

    task automatic test_busy();
        reg_write(fm_regs_pkg::ADDR_CT, 8'h80);
        check_eq("busy after write", 16'h1, 16'(dout[7]));
        check_eq("ct pins written", 16'h2, 16'({ct2, ct1}));
        bus_data(8'h40);                    // lost while busy is high
        check_eq("ct pins while busy", 16'h2, 16'({ct2, ct1}));
        reg_write(fm_regs_pkg::ADDR_CT, 8'h40);
        check_eq("ct pins after busy", 16'h1, 16'({ct2, ct1}));
    endtask

    task automatic test_timer_a();
        int period;
        timer_a_flag("timer A flag", 1, period);
        next_cycle();
        check_eq("timer A irq_n", 16'h0, 16'(irq_n));
        reg_write(fm_regs_pkg::ADDR_TIMER_CTRL, 8'h10);   // stop and clear A
        repeat (2) next_cycle();
        check_eq("timer A clear", 16'h2, 16'({irq_n, dout[0]}));
        reg_write(fm_regs_pkg::ADDR_TIMER_CTRL, 8'h01);   // run, irq off
        repeat (period + 4) next_cycle();
        check_eq("timer A masked", 16'h0, 16'(dout[0]));
        reg_write(fm_regs_pkg::ADDR_TIMER_CTRL, 8'h00);
    endtask

    task automatic test_timer_b();
        logic [7:0] val;
        int         ticks;
        val   = 8'd128 + 8'($urandom_range(127));
        ticks = 256 - int'(val);
        reg_write(fm_regs_pkg::ADDR_CLKB, val);
        reg_write(fm_regs_pkg::ADDR_TIMER_CTRL, 8'h0A);   // run B, irq enable B
        time_flag("timer B flag", 1, (ticks - 1) * fm_timing_pkg::TIMER_B_PRESCALE,
                  (ticks + 1) * fm_timing_pkg::TIMER_B_PRESCALE);
        check_eq("timer B status", 16'h2, 16'(dout[1:0]));
        reg_write(fm_regs_pkg::ADDR_TIMER_CTRL, 8'h20);
        repeat (2) next_cycle();
        check_eq("timer B clear", 16'h2, 16'({irq_n, dout[1]}));
    endtask

    task automatic test_cen_gating();
        int period;
        half_cen = 1'b1;
        timer_a_flag("timer A at half cen", 2, period);
        reg_write(fm_regs_pkg::ADDR_TIMER_CTRL, 8'h10);
        half_cen = 1'b0;
        repeat (2) next_cycle();
    endtask

    task automatic test_voice(logic [1:0] pan);     // pan[0] left, pan[1] right
        logic [15:0] inc;
        logic [2:0]  sh;
        logic [15:0] exp_l;
        logic [15:0] exp_r;
        int          last_at;
        inc = 16'($urandom);
        sh  = 3'($urandom_range(7));
        last_at = -1;
        reg_write(fm_regs_pkg::ADDR_INC_HI, inc[15:8]);
        reg_write(fm_regs_pkg::ADDR_INC_LO, inc[7:0]);
        reg_write(fm_regs_pkg::ADDR_ATTEN, {5'h0, sh});
        reg_write(fm_regs_pkg::ADDR_PAN, {pan, 6'h0});
        repeat (6) begin
            next_cycle();
            while (!sample) next_cycle();
            if (last_at >= 0) begin     // one pulse per sample period
                check_eq("voice sample period", 16'(fm_timing_pkg::SAMPLE_DIV),
                         16'(cyc - last_at));
            end
            last_at = cyc;
            next_cycle();   // model has caught up on the falling edge
            check_eq("voice sample width", 16'h0, 16'(sample));
            exp_l = square_level(model_phase, sh, pan[0]);
            exp_r = square_level(model_phase, sh, pan[1]);
            check_eq("voice left", exp_l, left);
            check_eq("voice right", exp_r, right);
            check_eq("voice dac_left", exp_l + 16'h8000, dac_left);
            check_eq("voice dac_right", exp_r + 16'h8000, dac_right);
        end
    endtask

    initial begin
        void'($urandom(32'h78ad_700c));
        rst_n = 1'b0;
        cs_n  = 1'b1;
        wr_n  = 1'b1;
        a0    = 1'b0;
        din   = 8'h00;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        next_cycle();
        test_reset();
        test_busy();
        test_timer_a();
        test_timer_b();
        test_cen_gating();
        test_voice(2'($urandom_range(3)));
        test_voice(2'b01);
        test_voice(2'b10);
        $display("checks failed: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb.f
src/fm_regs_pkg.sv
src/fm_timing_pkg.sv
src/fm_mmr.sv
src/fm_timers.sv
src/fm_voice.sv
src/fm_chip.sv
verification/fm_chip_tb.sv

//--- Makefile
# Verilator flow for the sound chip testbench

TOP := fm_chip_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f tb.f --top-module $(TOP)

sim:
	verilator --binary --assert --timescale 1ns/1ps -f tb.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
